// File: logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define NB_WORD      32            // Data and address width
`define N_REGS       32            // Register file depth
`define NB_REG_ADDR  5             // Register index width
`define LINK_REG     31            // JAL destination
`define RESET_PC     32'h0000_0000 // First fetch address

`endif

// File: logic/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

  typedef struct packed {
    logic [5:0]              opcode;
    logic [`NB_REG_ADDR-1:0] rs;
    logic [`NB_REG_ADDR-1:0] rt;
    logic [`NB_REG_ADDR-1:0] rd;
    logic [4:0]              shamt;
    logic [5:0]              funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]              opcode;
    logic [`NB_REG_ADDR-1:0] rs;
    logic [`NB_REG_ADDR-1:0] rt;
    logic [15:0]             imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index;
  } j_fmt_t;

  // One instruction word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_u;

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_AND = 4'd2;
  localparam alu_op_t ALU_OR  = 4'd3;
  localparam alu_op_t ALU_XOR = 4'd4;
  localparam alu_op_t ALU_SLT = 4'd5;
  localparam alu_op_t ALU_SLL = 4'd6;
  localparam alu_op_t ALU_LUI = 4'd7;

  typedef logic [2:0] flow_t;
  localparam flow_t FLOW_NONE     = 3'd0;
  localparam flow_t FLOW_BEQ      = 3'd1;
  localparam flow_t FLOW_BNE      = 3'd2;
  localparam flow_t FLOW_JUMP     = 3'd3;
  localparam flow_t FLOW_JUMP_REG = 3'd4;

  // Primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_JAL     = 6'h03;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_ANDI    = 6'h0c;
  localparam logic [5:0] OP_ORI     = 6'h0d;
  localparam logic [5:0] OP_LUI     = 6'h0f;

  // SPECIAL funct field
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: logic/mips_stage_ifs.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

interface fd_if;
  logic                valid;
  mips_pkg::instr_u    instr;
  logic [`NB_WORD-1:0] pc_plus4;

  modport master (output valid, instr, pc_plus4);
  modport slave  (input  valid, instr, pc_plus4);
endinterface

interface de_if;
  logic                    valid;
  mips_pkg::alu_op_t       alu_op;
  mips_pkg::flow_t         flow;
  logic [`NB_WORD-1:0]     op_a;     // rs value
  logic [`NB_WORD-1:0]     op_b;     // rt value
  logic [`NB_REG_ADDR-1:0] rs_addr;
  logic [`NB_REG_ADDR-1:0] rt_addr;
  logic [`NB_WORD-1:0]     imm_ext;
  logic                    use_imm;
  logic [25:0]             j_index;
  logic [`NB_REG_ADDR-1:0] dest;     // Zero means no write
  logic                    link;
  logic [`NB_WORD-1:0]     pc_plus4;

  modport master (output valid, alu_op, flow, op_a, op_b, rs_addr, rt_addr,
                  imm_ext, use_imm, j_index, dest, link, pc_plus4);
  modport slave  (input  valid, alu_op, flow, op_a, op_b, rs_addr, rt_addr,
                  imm_ext, use_imm, j_index, dest, link, pc_plus4);
endinterface

interface er_if;
  logic                    valid;
  logic [`NB_REG_ADDR-1:0] dest;
  logic [`NB_WORD-1:0]     data;

  modport master (output valid, dest, data);
  modport slave  (input  valid, dest, data);
endinterface

// File: logic/instruction_fetch.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module instruction_fetch (
  input  logic                i_clock,
  input  logic                i_reset,
  input  logic                i_run,
  input  mips_pkg::instr_u    i_instruction,
  input  logic                i_redirect,
  input  logic [`NB_WORD-1:0] i_redirect_pc,
  output logic [`NB_WORD-1:0] o_fetch_addr,
  fd_if.master                o_fd
);

  logic [`NB_WORD-1:0] pc;
  logic [`NB_WORD-1:0] pc_next_seq;
  logic                fd_valid;
  mips_pkg::instr_u    fd_instr;
  logic [`NB_WORD-1:0] fd_pc_plus4;

  assign pc_next_seq  = pc + `NB_WORD'(4);
  assign o_fetch_addr = pc; // Memory answers in the same cycle

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      pc       <= `RESET_PC;
      fd_valid <= 1'b0;
    end else if (i_run) begin
      pc       <= i_redirect ? i_redirect_pc : pc_next_seq;
      fd_valid <= ~i_redirect; // Word in flight is on the wrong path
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_run) begin
      fd_instr    <= i_instruction;
      fd_pc_plus4 <= pc_next_seq;
    end
  end

  assign o_fd.valid    = fd_valid;
  assign o_fd.instr    = fd_instr;
  assign o_fd.pc_plus4 = fd_pc_plus4;

endmodule

// File: logic/instruction_decode.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module instruction_decode (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_run,
  fd_if.slave                     i_fd,
  input  logic                    i_squash,
  input  logic                    i_wr_en,
  input  logic [`NB_REG_ADDR-1:0] i_wr_addr,
  input  logic [`NB_WORD-1:0]     i_wr_data,
  de_if.master                    o_de
);

  logic [`NB_WORD-1:0]     regs [`N_REGS];
  logic [`NB_REG_ADDR-1:0] rs;
  logic [`NB_REG_ADDR-1:0] rt;
  logic [`NB_WORD-1:0]     rs_val;
  logic [`NB_WORD-1:0]     rt_val;

  mips_pkg::alu_op_t       alu_op;
  mips_pkg::flow_t         flow;
  logic                    use_imm;
  logic                    sign_ext;
  logic                    link;
  logic [`NB_REG_ADDR-1:0] dest_raw;
  logic [`NB_WORD-1:0]     imm_ext;

  assign rs = i_fd.instr.r.rs;
  assign rt = i_fd.instr.r.rt;

  always_ff @(posedge i_clock) begin
    if (i_wr_en) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // Register 0 is hardwired, same-cycle writes pass through
  assign rs_val = (rs == '0) ? '0 :
                  (i_wr_en && i_wr_addr == rs) ? i_wr_data : regs[rs];
  assign rt_val = (rt == '0) ? '0 :
                  (i_wr_en && i_wr_addr == rt) ? i_wr_data : regs[rt];

  always_comb begin
    alu_op   = mips_pkg::ALU_ADD;
    flow     = mips_pkg::FLOW_NONE;
    use_imm  = 1'b0;
    sign_ext = 1'b1;
    link     = 1'b0;
    dest_raw = '0;                                  // Unknown encodings fall out as no-ops
    case (i_fd.instr.r.opcode)
      mips_pkg::OP_SPECIAL: begin
        dest_raw = i_fd.instr.r.rd;
        case (i_fd.instr.r.funct)
          mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;  // Shift amount rides in imm_ext
          mips_pkg::FN_JR: begin
            flow     = mips_pkg::FLOW_JUMP_REG;
            dest_raw = '0;
          end
          default: dest_raw = '0;
        endcase
      end
      mips_pkg::OP_ADDIU: begin
        use_imm  = 1'b1;
        dest_raw = i_fd.instr.i.rt;
      end
      mips_pkg::OP_ANDI: begin
        alu_op   = mips_pkg::ALU_AND;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        dest_raw = i_fd.instr.i.rt;
      end
      mips_pkg::OP_ORI: begin
        alu_op   = mips_pkg::ALU_OR;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        dest_raw = i_fd.instr.i.rt;
      end
      mips_pkg::OP_LUI: begin
        alu_op   = mips_pkg::ALU_LUI;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        dest_raw = i_fd.instr.i.rt;
      end
      mips_pkg::OP_BEQ: flow = mips_pkg::FLOW_BEQ;
      mips_pkg::OP_BNE: flow = mips_pkg::FLOW_BNE;
      mips_pkg::OP_J:   flow = mips_pkg::FLOW_JUMP;
      mips_pkg::OP_JAL: begin
        flow     = mips_pkg::FLOW_JUMP;
        link     = 1'b1;
        dest_raw = `NB_REG_ADDR'(`LINK_REG);
      end
      default: ;
    endcase
  end

  assign imm_ext = sign_ext ? {{16{i_fd.instr.i.imm[15]}}, i_fd.instr.i.imm}
                            : {16'b0, i_fd.instr.i.imm};

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_de.valid <= 1'b0;
    end else if (i_run) begin
      o_de.valid <= i_fd.valid & ~i_squash;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_run) begin
      o_de.alu_op   <= alu_op;
      o_de.flow     <= flow;
      o_de.op_a     <= rs_val;
      o_de.op_b     <= rt_val;
      o_de.rs_addr  <= rs;
      o_de.rt_addr  <= rt;
      o_de.imm_ext  <= imm_ext;
      o_de.use_imm  <= use_imm;
      o_de.j_index  <= i_fd.instr.j.index;
      o_de.dest     <= dest_raw;
      o_de.link     <= link;
      o_de.pc_plus4 <= i_fd.pc_plus4;
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module execute_stage (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_run,
  de_if.slave                     i_de,
  input  logic                    i_fwd_en,
  input  logic [`NB_REG_ADDR-1:0] i_fwd_addr,
  input  logic [`NB_WORD-1:0]     i_fwd_data,
  output logic                    o_redirect,
  output logic [`NB_WORD-1:0]     o_redirect_pc,
  er_if.master                    o_er
);

  logic                    er_valid;
  logic [`NB_REG_ADDR-1:0] er_dest;
  logic [`NB_WORD-1:0]     er_data;
  logic [`NB_WORD-1:0]     op_a;
  logic [`NB_WORD-1:0]     op_b;
  logic [`NB_WORD-1:0]     alu_b;
  logic [`NB_WORD-1:0]     alu_out;
  logic [`NB_WORD-1:0]     result;
  logic                    taken;

  // Newest producer wins, then the one in write-back
  function automatic logic [`NB_WORD-1:0] fwd_pick(
    input logic [`NB_REG_ADDR-1:0] addr,
    input logic [`NB_WORD-1:0]     reg_val
  );
    if (er_valid && er_dest != '0 && er_dest == addr) begin
      return er_data;
    end else if (i_fwd_en && i_fwd_addr != '0 && i_fwd_addr == addr) begin
      return i_fwd_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a = fwd_pick(i_de.rs_addr, i_de.op_a);
    op_b = fwd_pick(i_de.rt_addr, i_de.op_b);
  end

  assign alu_b = i_de.use_imm ? i_de.imm_ext : op_b;

  always_comb begin
    case (i_de.alu_op)
      mips_pkg::ALU_SUB: alu_out = op_a - alu_b;
      mips_pkg::ALU_AND: alu_out = op_a & alu_b;
      mips_pkg::ALU_OR:  alu_out = op_a | alu_b;
      mips_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
      mips_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
      mips_pkg::ALU_SLL: alu_out = op_b << i_de.imm_ext[10:6]; // shamt field
      mips_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'b0};
      default:           alu_out = op_a + alu_b;
    endcase
  end

  assign result = i_de.link ? i_de.pc_plus4 : alu_out;

  always_comb begin
    taken         = 1'b0;
    o_redirect_pc = i_de.pc_plus4 + {i_de.imm_ext[29:0], 2'b00};
    case (i_de.flow)
      mips_pkg::FLOW_BEQ: taken = (op_a == op_b);
      mips_pkg::FLOW_BNE: taken = (op_a != op_b);
      mips_pkg::FLOW_JUMP: begin
        taken         = 1'b1;
        o_redirect_pc = {i_de.pc_plus4[31:28], i_de.j_index, 2'b00};
      end
      mips_pkg::FLOW_JUMP_REG: begin
        taken         = 1'b1;
        o_redirect_pc = op_a;
      end
      default: ;
    endcase
  end

  // Held to run cycles so one redirect shows exactly once
  assign o_redirect = i_run & i_de.valid & taken;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      er_valid <= 1'b0;
    end else if (i_run) begin
      er_valid <= i_de.valid;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_run) begin
      er_dest <= i_de.dest;
      er_data <= result;
    end
  end

  assign o_er.valid = er_valid;
  assign o_er.dest  = er_dest;
  assign o_er.data  = er_data;

endmodule

// File: logic/result_stage.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module result_stage (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_run,
  er_if.slave                     i_er,
  output logic                    o_wr_en,
  output logic [`NB_REG_ADDR-1:0] o_wr_addr,
  output logic [`NB_WORD-1:0]     o_wr_data
);

  logic wb_valid;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      wb_valid <= 1'b0;
    end else if (i_run) begin
      wb_valid <= i_er.valid;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_run) begin
      o_wr_addr <= i_er.dest;
      o_wr_data <= i_er.data;
    end
  end

  // Commit only on a run edge, so a held entry writes once
  assign o_wr_en = i_run & wb_valid & (o_wr_addr != '0);

endmodule

// File: logic/mips_core.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_core (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_run,
  input  logic [`NB_WORD-1:0]     i_instruction,
  output logic [`NB_WORD-1:0]     o_fetch_addr,
  output logic                    o_wb_valid,
  output logic [`NB_REG_ADDR-1:0] o_wb_reg,
  output logic [`NB_WORD-1:0]     o_wb_data,
  output logic                    o_redirect,
  output logic [`NB_WORD-1:0]     o_redirect_pc
);

  fd_if fd_bus ();
  de_if de_bus ();
  er_if er_bus ();

  instruction_fetch u_fetch (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_run         (i_run),
    .i_instruction (i_instruction),
    .i_redirect    (o_redirect),
    .i_redirect_pc (o_redirect_pc),
    .o_fetch_addr  (o_fetch_addr),
    .o_fd          (fd_bus.master)
  );

  instruction_decode u_decode (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_run     (i_run),
    .i_fd      (fd_bus.slave),
    .i_squash  (o_redirect),    // Drops the slot behind a taken flow
    .i_wr_en   (o_wb_valid),
    .i_wr_addr (o_wb_reg),
    .i_wr_data (o_wb_data),
    .o_de      (de_bus.master)
  );

  execute_stage u_execute (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_run         (i_run),
    .i_de          (de_bus.slave),
    .i_fwd_en      (o_wb_valid),
    .i_fwd_addr    (o_wb_reg),
    .i_fwd_data    (o_wb_data),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_er          (er_bus.master)
  );

  result_stage u_result (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_run     (i_run),
    .i_er      (er_bus.slave),
    .o_wr_en   (o_wb_valid),
    .o_wr_addr (o_wb_reg),
    .o_wr_data (o_wb_data)
  );

endmodule

// File: tb/mips_core_tb.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_core_tb;

  localparam int MODEL_INSTRS = 2000;
  localparam int MARGIN       = 16;                     // Younger work still in flight at the end
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + MODEL_INSTRS * 8;

  logic                    clock;
  logic                    reset;
  logic                    run;
  logic [`NB_WORD-1:0]     instruction;
  logic [`NB_WORD-1:0]     fetch_addr;
  logic                    wb_valid;
  logic [`NB_REG_ADDR-1:0] wb_reg;
  logic [`NB_WORD-1:0]     wb_data;
  logic                    redirect;
  logic [`NB_WORD-1:0]     redirect_pc;

  mips_pkg::instr_u        program_mem [256];
  logic [31:0]             lfsr_state;
  logic [`NB_REG_ADDR-1:0] exp_wb_reg [$];
  logic [`NB_WORD-1:0]     exp_wb_data [$];
  logic [`NB_WORD-1:0]     exp_redirect [$];
  int                      wb_goal;
  int                      redirect_goal;
  int                      wb_seen;
  int                      redirect_seen;
  int                      cycle_count;
  bit                      error_seen;

  mips_core dut (
    .i_clock       (clock),
    .i_reset       (reset),
    .i_run         (run),
    .i_instruction (instruction),
    .o_fetch_addr  (fetch_addr),
    .o_wb_valid    (wb_valid),
    .o_wb_reg      (wb_reg),
    .o_wb_data     (wb_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    int          k;
    value = '0;
    for (k = 0; k < count; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // r0 to r7 and the link register
  function automatic logic [4:0] pick_reg();
    logic [3:0] v;
    v = 4'(random_bits(4));
    if (v == 4'd15) return 5'(`LINK_REG);
    if (v == 4'd0) return 5'd0;
    return 5'(1 + v % 7);
  endfunction

  function automatic mips_pkg::instr_u encode_r(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] shamt);
    mips_pkg::instr_u w;
    w.r = {mips_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
    return w;
  endfunction

  function automatic mips_pkg::instr_u encode_i(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
    mips_pkg::instr_u w;
    w.i = {op, rs, rt, imm};
    return w;
  endfunction

  function automatic mips_pkg::instr_u encode_j(input logic [5:0] op, input logic [25:0] index);
    mips_pkg::instr_u w;
    w.j = {op, index};
    return w;
  endfunction

  task automatic build_program();
    logic [3:0]  kind;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [7:0]  word;
    logic [15:0] imm;
    int          idx;
    for (idx = 0; idx < 8; idx++) begin                  // Prologue defines every readable register
      rd = (idx == 0) ? 5'(`LINK_REG) : 5'(idx);
      program_mem[idx] = encode_i(mips_pkg::OP_ADDIU, 5'd0, rd, 16'(random_bits(16)));
    end
    idx = 8;
    while (idx < 256) begin
      kind = 4'(random_bits(4));
      rs   = pick_reg();
      rt   = pick_reg();
      rd   = pick_reg();
      imm  = 16'(random_bits(16));
      word = 8'(random_bits(8));
      case (kind)
        4'd0:  program_mem[idx] = encode_r(mips_pkg::FN_ADDU, rs, rt, rd, 5'd0);
        4'd1:  program_mem[idx] = encode_r(mips_pkg::FN_SUBU, rs, rt, rd, 5'd0);
        4'd2:  program_mem[idx] = encode_r(mips_pkg::FN_AND, rs, rt, rd, 5'd0);
        4'd3:  program_mem[idx] = encode_r(mips_pkg::FN_OR, rs, rt, rd, 5'd0);
        4'd4:  program_mem[idx] = encode_r(mips_pkg::FN_XOR, rs, rt, rd, 5'd0);
        4'd5:  program_mem[idx] = encode_r(mips_pkg::FN_SLT, rs, rt, rd, 5'd0);
        4'd6:  program_mem[idx] = encode_r(mips_pkg::FN_SLL, 5'd0, rt, rd, imm[4:0]);
        4'd8:  program_mem[idx] = encode_i(mips_pkg::OP_ORI, rs, rt, imm);
        4'd9:  program_mem[idx] = encode_i(mips_pkg::OP_ANDI, rs, rt, imm);
        4'd10: program_mem[idx] = encode_i(mips_pkg::OP_LUI, 5'd0, rt, imm);
        4'd11: program_mem[idx] = encode_i(mips_pkg::OP_BEQ, rs, rt, {12'd0, imm[3:0]});
        4'd12: program_mem[idx] = encode_i(mips_pkg::OP_BNE, rs, rt, {12'd0, imm[3:0]});
        4'd13: program_mem[idx] = encode_j(imm[15] ? mips_pkg::OP_JAL : mips_pkg::OP_J,
                                           {18'd0, word});
        4'd14: begin
          if (idx <= 253) begin                          // Aligned target built just before JR
            rd = 5'(1 + imm[2:0] % 7);
            program_mem[idx]     = encode_i(mips_pkg::OP_LUI, 5'd0, rd, 16'd0);
            program_mem[idx + 1] = encode_i(mips_pkg::OP_ORI, rd, rd, {6'd0, word, 2'b00});
            program_mem[idx + 2] = encode_r(mips_pkg::FN_JR, rd, 5'd0, 5'd0, 5'd0);
            idx += 2;
          end else begin
            program_mem[idx] = encode_i(mips_pkg::OP_ADDIU, rs, rt, imm);
          end
        end
        default: program_mem[idx] = encode_i(mips_pkg::OP_ADDIU, rs, rt, imm);
      endcase
      idx++;
    end
  endtask

  // ISA interpreter without a delay slot
  task automatic run_model();
    logic [`NB_WORD-1:0]     regs [`N_REGS];
    logic [`NB_WORD-1:0]     pc;
    logic [`NB_WORD-1:0]     pc4;
    logic [`NB_WORD-1:0]     a;
    logic [`NB_WORD-1:0]     b;
    logic [`NB_WORD-1:0]     simm;
    logic [`NB_WORD-1:0]     value;
    logic [`NB_WORD-1:0]     target;
    logic [`NB_REG_ADDR-1:0] dest;
    logic                    taken;
    mips_pkg::instr_u        ins;
    int                      n;
    for (n = 0; n < `N_REGS; n++) begin
      regs[n] = '0;
    end
    pc = `RESET_PC;
    for (n = 0; n < MODEL_INSTRS + MARGIN; n++) begin
      if (n == MODEL_INSTRS) begin
        wb_goal       = exp_wb_reg.size();
        redirect_goal = exp_redirect.size();
      end
      ins    = program_mem[pc[9:2]];                       // Memory wraps at 256 words
      pc4    = pc + 32'd4;
      a      = regs[ins.r.rs];
      b      = regs[ins.r.rt];
      simm   = {{16{ins.i.imm[15]}}, ins.i.imm};
      dest   = '0;
      value  = '0;
      taken  = 1'b0;
      target = '0;
      case (ins.r.opcode)
        mips_pkg::OP_SPECIAL: begin
          dest = ins.r.rd;
          case (ins.r.funct)
            mips_pkg::FN_ADDU: value = a + b;
            mips_pkg::FN_SUBU: value = a - b;
            mips_pkg::FN_AND:  value = a & b;
            mips_pkg::FN_OR:   value = a | b;
            mips_pkg::FN_XOR:  value = a ^ b;
            mips_pkg::FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mips_pkg::FN_SLL:  value = b << ins.r.shamt;
            mips_pkg::FN_JR: begin
              dest   = '0;
              taken  = 1'b1;
              target = a;
            end
            default: dest = '0;
          endcase
        end
        mips_pkg::OP_ADDIU: begin
          dest  = ins.i.rt;
          value = a + simm;
        end
        mips_pkg::OP_ANDI: begin
          dest  = ins.i.rt;
          value = a & {16'h0000, ins.i.imm};               // Zero extended
        end
        mips_pkg::OP_ORI: begin
          dest  = ins.i.rt;
          value = a | {16'h0000, ins.i.imm};
        end
        mips_pkg::OP_LUI: begin
          dest  = ins.i.rt;
          value = {ins.i.imm, 16'h0000};
        end
        mips_pkg::OP_BEQ: begin
          taken  = (a == b);
          target = pc4 + (simm << 2);
        end
        mips_pkg::OP_BNE: begin
          taken  = (a != b);
          target = pc4 + (simm << 2);
        end
        mips_pkg::OP_J, mips_pkg::OP_JAL: begin
          taken  = 1'b1;
          target = {pc4[31:28], ins.j.index, 2'b00};
          if (ins.j.opcode == mips_pkg::OP_JAL) begin
            dest  = 5'(`LINK_REG);
            value = pc4;
          end
        end
        default: ;
      endcase
      if (dest != '0) begin                              // r0 stays zero and never retires
        regs[dest] = value;
        exp_wb_reg.push_back(dest);
        exp_wb_data.push_back(value);
      end
      if (taken) begin
        exp_redirect.push_back(target);
      end
      pc = taken ? target : pc4;
    end
  endtask

  task automatic check_wb(input logic [`NB_REG_ADDR-1:0] act_reg,
                          input logic [`NB_WORD-1:0] act_data);
    logic [`NB_REG_ADDR-1:0] exp_reg;
    logic [`NB_WORD-1:0]     exp_data;
    if (exp_wb_reg.size() == 0) begin
      $display("write-back to r%0d came after the model had none left", act_reg);
      error_seen = 1'b1;
    end else begin
      exp_reg  = exp_wb_reg.pop_front();
      exp_data = exp_wb_data.pop_front();
      if (act_reg !== exp_reg || act_data !== exp_data) begin
        $display("error writeback #%0d: expected r%0d=%h actual r%0d=%h",
                 wb_seen, exp_reg, exp_data, act_reg, act_data);
        error_seen = 1'b1;
      end
      wb_seen++;
    end
  endtask

  task automatic check_redirect(input logic [`NB_WORD-1:0] act_pc);
    logic [`NB_WORD-1:0] exp_pc;
    if (exp_redirect.size() == 0) begin
      $display("redirect to %h came after the model had none left", act_pc);
      error_seen = 1'b1;
    end else begin
      exp_pc = exp_redirect.pop_front();
      if (act_pc !== exp_pc) begin
        $display("error redirect #%0d: expected %h actual %h", redirect_seen, exp_pc, act_pc);
        error_seen = 1'b1;
      end
      redirect_seen++;
    end
  endtask

  initial begin : clock_gen
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin : stimulus
    int reset_cycles;
    reset        = 1'b1;
    run          = 1'b1;
    instruction  = '0;
    reset_cycles = 0;
    forever begin
      @(negedge clock);
      instruction = program_mem[fetch_addr[9:2]];        // Same-cycle instruction memory
      reset_cycles++;
      if (reset_cycles >= RESET_CYCLES) begin
        reset = 1'b0;
        run   = (random_bits(3) != 32'd0);               // Stall about one cycle in eight
      end
    end
  end

  initial begin : scoreboard
    lfsr_state    = 32'hd081;
    wb_seen       = 0;
    redirect_seen = 0;
    cycle_count   = 0;
    error_seen    = 1'b0;
    build_program();
    run_model();
    while (!error_seen && (wb_seen < wb_goal || redirect_seen < redirect_goal) &&
           cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
      if (!reset && wb_valid) begin
        check_wb(wb_reg, wb_data);
      end
      if (!reset && redirect && !error_seen) begin
        check_redirect(redirect_pc);
      end
    end
    if (!error_seen && wb_seen >= wb_goal && redirect_seen >= redirect_goal) begin
      $display("Test OK");
      $finish;
    end else begin
      if (!error_seen) begin
        $display("timeout: pipeline stopped retiring");
      end
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

// File: mips_core.f
+incdir+logic
logic/mips_pkg.sv
logic/mips_stage_ifs.sv
logic/instruction_fetch.sv
logic/instruction_decode.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_core.sv
tb/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_pkg.sv
      - logic/mips_stage_ifs.sv
      - logic/instruction_fetch.sv
      - logic/instruction_decode.sv
      - logic/execute_stage.sv
      - logic/result_stage.sv
      - logic/mips_core.sv
      - target: simulation
        files:
          - tb/mips_core_tb.sv
